// File: Makefile
# Verilator build and run for the multicycle processor

VERILATOR ?= verilator
TOP       ?= tbProc
FILELIST  ?= sources.f
LOG       ?= sim.log
OBJDIR    ?= obj_dir
VFLAGS    ?= --binary --timing --assert
LINTFLAGS ?= --lint-only --timing -Wall

.PHONY: run build lint clean

run: build
	./$(OBJDIR)/V$(TOP) | tee $(LOG)
	@grep -q "All tests passed" $(LOG) || (echo "Simulation failed, see $(LOG)"; exit 1)

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJDIR) $(LOG)

// File: aluUnit.sv
// ALU with A and G registers
module aluUnit #(
  parameter int DataWidth = 16
) (
  input  logic                 clock,
  input  logic                 arstN,
  input  logic                 aIn,    // Load A from bus
  input  logic                 gIn,    // Load G with result
  input  procPkg::aluOp_e      aluOp,
  input  logic [DataWidth-1:0] busIn,
  output logic [DataWidth-1:0] gValue,
  output logic                 gZero
);
  import procPkg::*;

  logic [DataWidth-1:0] aReg;   // First operand
  logic [DataWidth-1:0] gReg;   // Result
  logic [DataWidth-1:0] result; // A op bus

  always_comb
  begin
    case (aluOp)
      aluAdd:  result = aReg + busIn; // Wraps
      aluSub:  result = aReg - busIn; // Wraps
      aluSlt:  result = (aReg < busIn) ? DataWidth'(1) : '0; // Unsigned compare
      default: result = '0;
    endcase
  end

  always_ff @(posedge clock or negedge arstN)
  begin
    if (!arstN)
    begin
      aReg <= '0;
      gReg <= '0;
    end
    else
    begin
      if (aIn)
        aReg <= busIn;
      if (gIn)
        gReg <= result;
    end
  end

  assign gValue = gReg;
  assign gZero  = (gReg == '0); // mvnz condition

endmodule

// File: controlUnit.sv
// Multicycle control unit
module controlUnit (
  input  logic clock,
  input  logic arstN,
  input  logic run,      // Start or continue fetching
  output logic wrEn,     // Memory write strobe
  output logic done,     // Last step of an instruction
  ctrlIf.ctrl  ctrlPort  // Strobes out and IR fields in
);
  import procPkg::*;

  localparam regSel_t PcSel = regSel_t'(1 << PcIndex); // One-hot R7

  tStep_t  step;  // Current step
  regSel_t rxSel; // One-hot Rx
  regSel_t rySel; // One-hot Ry
  aluOp_e  opAlu; // ALU function of the opcode

  // Step counter holds T0 while run is low
  always_ff @(posedge clock or negedge arstN)
  begin
    if (!arstN)
      step <= T0;
    else if (done)
      step <= T0; // Back to fetch
    else if (step != T0 || run)
      step <= tStep_t'(step + 3'd1);
  end

  // Field decoders
  always_comb
  begin
    rxSel = '0;
    rySel = '0;
    rxSel[ctrlPort.fields.rx] = 1'b1;
    rySel[ctrlPort.fields.ry] = 1'b1;
  end

  // Opcode to ALU function
  always_comb
  begin
    case (ctrlPort.fields.opcode)
      sub:     opAlu = aluSub;
      slt:     opAlu = aluSlt;
      default: opAlu = aluAdd;
    endcase
  end

  // Strobe table
  always_comb
  begin
    ctrlPort.rIn    = '0;
    ctrlPort.rOut   = '0;
    ctrlPort.irIn   = 1'b0;
    ctrlPort.addrIn = 1'b0;
    ctrlPort.doutIn = 1'b0;
    ctrlPort.dinOut = 1'b0;
    ctrlPort.aIn    = 1'b0;
    ctrlPort.gIn    = 1'b0;
    ctrlPort.gOut   = 1'b0;
    ctrlPort.incrPc = 1'b0;
    ctrlPort.aluOp  = aluAdd;
    wrEn            = 1'b0;
    done            = 1'b0;

    case (step)
      T0:
      begin
        if (run)
        begin
          ctrlPort.rOut   = PcSel; // PC to address register
          ctrlPort.addrIn = 1'b1;
        end
      end
      T1: ; // Memory read in flight
      T2:
      begin
        ctrlPort.dinOut = 1'b1; // Instruction word into IR
        ctrlPort.irIn   = 1'b1;
        ctrlPort.incrPc = 1'b1;
      end
      T3:
      begin
        case (ctrlPort.fields.opcode)
          mv:
          begin
            ctrlPort.rOut = rySel;
            ctrlPort.rIn  = rxSel;
            done          = 1'b1;
          end
          mvnz:
          begin
            ctrlPort.rOut = ctrlPort.gZero ? rxSel : rySel; // Rx rewrites itself on zero
            ctrlPort.rIn  = rxSel;
            done          = 1'b1;
          end
          mvi:
          begin
            ctrlPort.rOut   = PcSel; // PC now points at the immediate
            ctrlPort.addrIn = 1'b1;
          end
          add, sub, slt:
          begin
            ctrlPort.rOut = rxSel; // First operand into A
            ctrlPort.aIn  = 1'b1;
          end
          ld:
          begin
            ctrlPort.rOut   = rySel;
            ctrlPort.addrIn = 1'b1;
          end
          st:
          begin
            ctrlPort.rOut   = rxSel; // Store data
            ctrlPort.doutIn = 1'b1;
          end
          default: done = 1'b1; // Unused opcode does nothing
        endcase
      end
      T4:
      begin
        case (ctrlPort.fields.opcode)
          add, sub, slt:
          begin
            ctrlPort.rOut  = rySel;
            ctrlPort.aluOp = opAlu;
            ctrlPort.gIn   = 1'b1;
          end
          st:
          begin
            ctrlPort.rOut   = rySel; // Store address
            ctrlPort.addrIn = 1'b1;
          end
          default: ; // mvi and ld wait for memory
        endcase
      end
      T5:
      begin
        done = 1'b1;
        case (ctrlPort.fields.opcode)
          mvi:
          begin
            ctrlPort.dinOut = 1'b1;
            ctrlPort.rIn    = rxSel;
            ctrlPort.incrPc = 1'b1; // Skip past the immediate
          end
          add, sub, slt:
          begin
            ctrlPort.gOut = 1'b1;
            ctrlPort.rIn  = rxSel;
          end
          ld:
          begin
            ctrlPort.dinOut = 1'b1;
            ctrlPort.rIn    = rxSel;
          end
          default: wrEn = 1'b1; // st with its address now valid
        endcase
      end
      default: done = 1'b1; // Unreachable step recovers to T0
    endcase
  end

endmodule

// File: ctrlIf.sv
// Control to datapath link
interface ctrlIf;
  import procPkg::*;

  regSel_t      rIn;    // Register load selects
  regSel_t      rOut;   // Register bus drive selects
  logic         irIn;   // Load IR
  logic         addrIn; // Load address register
  logic         doutIn; // Load data-out register
  logic         dinOut; // Memory data onto bus
  logic         aIn;    // Load A
  logic         gIn;    // Load G
  logic         gOut;   // G onto bus
  logic         incrPc; // PC + 1
  aluOp_e       aluOp;  // ALU function for gIn
  instrFields_t fields; // Decoded IR
  logic         gZero;  // G is zero

  // Control unit side
  modport ctrl (
    output rIn, rOut, irIn, addrIn, doutIn, dinOut,
    output aIn, gIn, gOut, incrPc, aluOp,
    input  fields, gZero
  );

  // Datapath side
  modport dp (
    input  rIn, rOut, irIn, addrIn, doutIn, dinOut,
    input  aIn, gIn, gOut, incrPc, aluOp,
    output fields, gZero
  );

endinterface

// File: datapath.sv
// Processor datapath
module datapath #(
  parameter int DataWidth = 16
) (
  input  logic                 clock,
  input  logic                 arstN,
  input  logic [DataWidth-1:0] din,    // Memory read data
  output logic [DataWidth-1:0] addr,   // Memory address
  output logic [DataWidth-1:0] dout,   // Memory write data
  ctrlIf.dp                    dpPort  // Strobes in, fields out
);
  import procPkg::*;

  logic [DataWidth-1:0] bus;     // Shared bus
  logic [DataWidth-1:0] regOut;  // Selected register
  logic [DataWidth-1:0] gValue;  // G contents
  logic [DataWidth-1:0] addrReg; // Address register
  logic [DataWidth-1:0] doutReg; // Data-out register
  instrFields_t         irReg;   // IR, only the decoded bits kept

  regFile #(
    .DataWidth (DataWidth)
  ) u_regFile (
    .clock  (clock),
    .arstN  (arstN),
    .rIn    (dpPort.rIn),
    .rOut   (dpPort.rOut),
    .incrPc (dpPort.incrPc),
    .busIn  (bus),
    .busOut (regOut)
  );

  aluUnit #(
    .DataWidth (DataWidth)
  ) u_aluUnit (
    .clock  (clock),
    .arstN  (arstN),
    .aIn    (dpPort.aIn),
    .gIn    (dpPort.gIn),
    .aluOp  (dpPort.aluOp),
    .busIn  (bus),
    .gValue (gValue),
    .gZero  (dpPort.gZero)
  );

  // Bus source, one active at a time
  always_comb
  begin
    if (dpPort.dinOut)
      bus = din;
    else if (dpPort.gOut)
      bus = gValue;
    else
      bus = regOut; // Zero when no register drives
  end

  always_ff @(posedge clock or negedge arstN)
  begin
    if (!arstN)
    begin
      irReg   <= '0;
      addrReg <= '0;
      doutReg <= '0;
    end
    else
    begin
      if (dpPort.irIn)
      begin
        irReg.opcode <= opcode_e'(bus[OpcodeLsb +: $bits(opcode_e)]);
        irReg.rx     <= bus[RxLsb +: $bits(irReg.rx)];
        irReg.ry     <= bus[RyLsb +: $bits(irReg.ry)];
      end
      if (dpPort.addrIn)
        addrReg <= bus;
      if (dpPort.doutIn)
        doutReg <= bus;
    end
  end

  assign dpPort.fields = irReg;
  assign addr          = addrReg;
  assign dout          = doutReg;

endmodule

// File: procPkg.sv
// Processor shared definitions
package procPkg;

  localparam int NumRegs   = 8; // R0..R7
  localparam int PcIndex   = 7; // R7 is the program counter
  localparam int OpcodeLsb = 6; // Opcode in IR[9:6]
  localparam int RxLsb     = 3; // Destination field in IR[5:3]
  localparam int RyLsb     = 0; // Source field in IR[2:0]

  // Instruction opcodes, codes 6 and 9..15 do nothing
  typedef enum logic [3:0] {
    mv   = 4'd0, // Rx <- Ry
    mvi  = 4'd1, // Rx <- next word
    mvnz = 4'd2, // Rx <- Ry if G != 0
    add  = 4'd3, // Rx <- Rx + Ry
    sub  = 4'd4, // Rx <- Rx - Ry
    slt  = 4'd5, // Rx <- (Rx < Ry), unsigned
    ld   = 4'd7, // Rx <- mem[Ry]
    st   = 4'd8  // mem[Ry] <- Rx
  } opcode_e;

  // ALU function applied as A op bus
  typedef enum logic [1:0] {
    aluAdd = 2'd0, // Wrapping sum
    aluSub = 2'd1, // Wrapping difference
    aluSlt = 2'd2  // Unsigned set-less-than
  } aluOp_e;

  // Step counter, one step per clock
  typedef enum logic [2:0] {
    T0, T1, T2, T3, T4, T5
  } tStep_t;

  // One-hot register select, bit i is Ri
  typedef logic [NumRegs-1:0] regSel_t;

  // Decoded IR fields
  typedef struct packed {
    opcode_e    opcode; // IR[9:6]
    logic [2:0] rx;     // IR[5:3]
    logic [2:0] ry;     // IR[2:0]
  } instrFields_t;

endpackage

// File: procTop.sv
// Multicycle processor top
module procTop #(
  parameter int DataWidth = 16
) (
  input  logic                 clock,
  input  logic                 arstN,
  input  logic                 run,  // Fetch enable, sampled in T0
  input  logic [DataWidth-1:0] din,  // Read data, one cycle after addr
  output logic [DataWidth-1:0] addr, // Address register
  output logic [DataWidth-1:0] dout, // Write data
  output logic                 wrEn, // Write dout to addr
  output logic                 done  // Instruction complete
);

  ctrlIf u_ctrlIf (); // Control and status link

  controlUnit u_controlUnit (
    .clock    (clock),
    .arstN    (arstN),
    .run      (run),
    .wrEn     (wrEn),
    .done     (done),
    .ctrlPort (u_ctrlIf.ctrl)
  );

  datapath #(
    .DataWidth (DataWidth)
  ) u_datapath (
    .clock  (clock),
    .arstN  (arstN),
    .din    (din),
    .addr   (addr),
    .dout   (dout),
    .dpPort (u_ctrlIf.dp)
  );

endmodule

// File: regFile.sv
// General register file
module regFile #(
  parameter int DataWidth = 16
) (
  input  logic                   clock,
  input  logic                   arstN,
  input  procPkg::regSel_t       rIn,    // One-hot load
  input  procPkg::regSel_t       rOut,   // One-hot read
  input  logic                   incrPc, // Bump R7
  input  logic [DataWidth-1:0]   busIn,
  output logic [DataWidth-1:0]   busOut
);
  import procPkg::*;

  logic [DataWidth-1:0] regs [NumRegs]; // R0..R7

  // Register writes
  always_ff @(posedge clock or negedge arstN)
  begin
    if (!arstN)
    begin
      for (int i = 0; i < NumRegs; i++)
      begin
        regs[i] <= '0; // First fetch from address 0
      end
    end
    else
    begin
      for (int i = 0; i < NumRegs; i++)
      begin
        if (rIn[i])
          regs[i] <= busIn; // Bus load wins over increment
        else if (i == PcIndex && incrPc)
          regs[i] <= regs[i] + DataWidth'(1);
      end
    end
  end

  // AND-OR read mux, zero when nothing selected
  always_comb
  begin
    busOut = '0;
    for (int i = 0; i < NumRegs; i++)
    begin
      if (rOut[i])
        busOut = busOut | regs[i];
    end
  end

endmodule

// File: sources.f
procPkg.sv
ctrlIf.sv
controlUnit.sv
regFile.sv
aluUnit.sv
datapath.sv
procTop.sv
tbProc.sv

// File: tbProc.sv
// Processor directed testbench
module tbProc;

  localparam int ClkPeriod      = 40;
  localparam int DataWidth      = 16;
  localparam int TotalInstr     = 47; // 9 + 18 + 13 + 4 + 3 instructions
  localparam int WatchdogCycles = 6 * TotalInstr + 200;

  // Instruction codes
  localparam logic [3:0] OpMv   = 4'd0;
  localparam logic [3:0] OpMvi  = 4'd1;
  localparam logic [3:0] OpMvnz = 4'd2;
  localparam logic [3:0] OpAdd  = 4'd3;
  localparam logic [3:0] OpSub  = 4'd4;
  localparam logic [3:0] OpSlt  = 4'd5;
  localparam logic [3:0] OpLd   = 4'd7;
  localparam logic [3:0] OpSt   = 4'd8;

  logic                 clock;
  logic                 arstN;
  logic                 run;
  logic [DataWidth-1:0] din = '0; // Driven by the memory model
  logic [DataWidth-1:0] addr;
  logic [DataWidth-1:0] dout;
  logic                 wrEn;
  logic                 done;

  logic [DataWidth-1:0] mem [256];  // Program and data
  logic [7:0]           rdAddr;     // Address seen at the edge
  logic [DataWidth-1:0] prog [$];   // Program image
  int                   expCycles [$]; // Expected cycles per instruction
  logic [DataWidth-1:0] wrAddrs [$];   // Addresses written during a run
  integer               seed = 32'hf61a_8479;
  int                   testsRun    = 0;
  int                   testsFailed = 0;
  int                   errorCount  = 0;
  int                   testErrors  = 0; // Errors in the current test

  procTop #(
    .DataWidth (DataWidth)
  ) u_procTop (
    .clock (clock),
    .arstN (arstN),
    .run   (run),
    .din   (din),
    .addr  (addr),
    .dout  (dout),
    .wrEn  (wrEn),
    .done  (done)
  );

  initial
  begin
    clock = 1'b0;
    forever #(ClkPeriod / 2) clock = ~clock;
  end

  // Synchronous memory, din follows addr by one cycle
  always @(posedge clock)
  begin
    rdAddr = addr[7:0];
    if (wrEn === 1'b1)
      mem[rdAddr] = dout;
    #2 din = mem[rdAddr];
  end

  function automatic logic [15:0] randWord();
    logic [31:0] r;
    r = $random(seed);
    return r[15:0];
  endfunction

  function automatic logic [15:0] encode(input logic [3:0] op, input logic [2:0] rx,
                                         input logic [2:0] ry);
    return {6'h2d, op, rx, ry}; // Upper bits are don't-care
  endfunction

  function automatic void newProgram();
    prog.delete();
    expCycles.delete();
  endfunction

  // Four cycles for the moves, six for the rest
  function automatic void emitOp(input logic [3:0] op, input logic [2:0] rx,
                                 input logic [2:0] ry);
    prog.push_back(encode(op, rx, ry));
    expCycles.push_back((op == OpMv || op == OpMvnz) ? 4 : 6);
  endfunction

  function automatic void emitMvi(input logic [2:0] rx, input logic [15:0] imm);
    prog.push_back(encode(OpMvi, rx, 3'd0));
    prog.push_back(imm); // Immediate word
    expCycles.push_back(6);
  endfunction

  function automatic void emitStore(input logic [2:0] src, input logic [2:0] addrReg,
                                    input logic [15:0] address);
    emitMvi(addrReg, address);
    emitOp(OpSt, src, addrReg);
  endfunction

  task automatic expectEq(input string name, input logic [15:0] got,
                          input logic [15:0] expected);
    assert (got === expected)
    else
    begin
      $display("Mismatch %s: got %h, expected %h", name, got, expected);
      testErrors++;
    end
  endtask

  task automatic finishTest(input string name);
    if (testErrors == 0)
      $display("%s: ok", name);
    else
    begin
      $display("%s: %0d errors", name, testErrors);
      testsFailed++;
    end
    errorCount += testErrors;
    testErrors = 0;
    testsRun++;
  endtask

  task automatic applyReset();
    @(posedge clock);
    #2;
    run   = 1'b0;
    arstN = 1'b0;
    repeat (10) @(posedge clock);
    #2 arstN = 1'b1;
  endtask

  // Fill tags each word with its address, then the program from 0
  task automatic loadProgram();
    for (int i = 0; i < 256; i++)
      mem[i[7:0]] = {8'hda, i[7:0]};
    for (int i = 0; i < prog.size(); i++)
      mem[i[7:0]] = prog[i];
  endtask

  // Runs until every expected done pulse has arrived, then halts
  task automatic runProgram();
    int cycles;
    int idx;
    cycles = 0;
    idx    = 0;
    wrAddrs.delete();
    @(posedge clock);
    #2 run = 1'b1;
    while (idx < expCycles.size())
    begin
      @(negedge clock);
      cycles++;
      if (wrEn)
        wrAddrs.push_back(addr);
      if (done)
      begin
        expectEq($sformatf("cycles of instruction %0d", idx), 16'(cycles),
                 16'(expCycles[idx]));
        idx++;
        cycles = 0;
      end
    end
    @(posedge clock);
    #2 run = 1'b0; // Holds in T0 from here
    repeat (2) @(posedge clock);
  endtask

  task automatic resetIdle();
    applyReset();
    repeat (20)
    begin
      @(negedge clock);
      expectEq("addr", addr, 16'h0000);
      expectEq("wrEn", 16'(wrEn), 16'h0000);
      expectEq("done", 16'(done), 16'h0000);
    end
    finishTest("resetIdle");
  endtask

  task automatic moveAndStore();
    logic [15:0] a;
    logic [15:0] b;
    a = randWord();
    b = randWord();
    applyReset();
    newProgram();
    emitMvi(3'd0, a);
    emitMvi(3'd1, b);
    emitOp(OpMv, 3'd2, 3'd0);       // Copy of a
    emitStore(3'd0, 3'd3, 16'h0080);
    emitStore(3'd1, 3'd3, 16'h0081);
    emitStore(3'd2, 3'd3, 16'h0082);
    loadProgram();
    runProgram();
    expectEq("mem[80]", mem[8'h80], a);
    expectEq("mem[81]", mem[8'h81], b);
    expectEq("mem[82]", mem[8'h82], a);
    finishTest("moveAndStore");
  endtask

  task automatic aluOps();
    logic [15:0] a;
    logic [15:0] b;
    a = randWord();
    b = randWord();
    applyReset();
    newProgram();
    emitMvi(3'd0, a);
    emitMvi(3'd1, b);
    emitOp(OpMv, 3'd2, 3'd0);
    emitOp(OpAdd, 3'd2, 3'd1);      // a + b
    emitOp(OpMv, 3'd3, 3'd0);
    emitOp(OpSub, 3'd3, 3'd1);      // a - b
    emitOp(OpMv, 3'd4, 3'd0);
    emitOp(OpSlt, 3'd4, 3'd1);      // a < b
    emitOp(OpMv, 3'd6, 3'd1);
    emitOp(OpSlt, 3'd6, 3'd0);      // b < a
    emitStore(3'd2, 3'd5, 16'h0090);
    emitStore(3'd3, 3'd5, 16'h0091);
    emitStore(3'd4, 3'd5, 16'h0092);
    emitStore(3'd6, 3'd5, 16'h0093);
    loadProgram();
    runProgram();
    expectEq("sum", mem[8'h90], 16'(a + b));
    expectEq("difference", mem[8'h91], 16'(a - b));
    expectEq("a < b", mem[8'h92], (a < b) ? 16'h0001 : 16'h0000);
    expectEq("b < a", mem[8'h93], (b < a) ? 16'h0001 : 16'h0000);
    finishTest("aluOps");
  endtask

  task automatic condMove();
    logic [15:0] a;
    logic [15:0] c;
    logic [15:0] d;
    a = randWord();
    c = a ^ 16'h00ff;  // Differs from a
    d = randWord();
    d[15] = 1'b0;      // Keeps 1 + d nonzero
    d[0]  = 1'b1;      // Nonzero, unlike reset R5
    applyReset();
    newProgram();
    emitMvi(3'd0, a);
    emitMvi(3'd1, a);
    emitMvi(3'd2, c);
    emitOp(OpSub, 3'd0, 3'd1);      // G becomes zero
    emitOp(OpMvnz, 3'd2, 3'd1);     // No copy
    emitMvi(3'd3, 16'h0001);
    emitMvi(3'd4, d);
    emitOp(OpAdd, 3'd3, 3'd4);      // G nonzero
    emitOp(OpMvnz, 3'd5, 3'd4);     // Copies d
    emitStore(3'd2, 3'd6, 16'h00a0);
    emitStore(3'd5, 3'd6, 16'h00a1);
    loadProgram();
    runProgram();
    expectEq("mvnz after zero", mem[8'ha0], c);
    expectEq("mvnz after nonzero", mem[8'ha1], d);
    finishTest("condMove");
  endtask

  task automatic loadStoreRoundTrip();
    logic [15:0] w;
    w = randWord();
    applyReset();
    newProgram();
    emitMvi(3'd1, 16'h00b0);
    emitOp(OpLd, 3'd2, 3'd1);
    emitMvi(3'd3, 16'h00b4);
    emitOp(OpSt, 3'd2, 3'd3);
    loadProgram();
    mem[8'hb0] = w;                 // Source word
    runProgram();
    expectEq("mem[b4]", mem[8'hb4], w);
    expectEq("mem[b0]", mem[8'hb0], w);
    expectEq("write count", 16'(wrAddrs.size()), 16'h0001);
    if (wrAddrs.size() > 0)
      expectEq("addr on write", wrAddrs[0], 16'h00b4);
    finishTest("loadStoreRoundTrip");
  endtask

  task automatic runGating();
    logic [15:0] x;
    logic [15:0] holdAddr;
    int          cycles;
    int          doneCount;
    x         = randWord();
    holdAddr  = '0;
    cycles    = 1;                  // T0 already counted
    doneCount = 0;
    applyReset();
    newProgram();
    emitMvi(3'd0, x);
    emitStore(3'd0, 3'd1, 16'h00c0);
    loadProgram();
    @(posedge clock);
    #2 run = 1'b1;
    @(posedge clock);
    #2 run = 1'b0;                  // Dropped in T1
    repeat (30)
    begin
      @(negedge clock);
      if (doneCount == 0)
        cycles++;
      if (done)
      begin
        doneCount++;
        expectEq("cycles with run low", 16'(cycles), 16'(expCycles[0]));
        holdAddr = addr;
      end
      else if (doneCount > 0)
      begin
        expectEq("addr while halted", addr, holdAddr);
        expectEq("wrEn while halted", 16'(wrEn), 16'h0000);
      end
    end
    assert (doneCount == 1)
    else
    begin
      $display("Run gating: saw %0d done pulses after run dropped, expected 1", doneCount);
      testErrors++;
    end
    expCycles.delete(0);            // First instruction already ran
    runProgram();
    expectEq("mem[c0]", mem[8'hc0], x);
    finishTest("runGating");
  endtask

  // Ends a run that stalls
  initial
  begin
    #(WatchdogCycles * ClkPeriod);
    $display("Watchdog expired after %0d cycles, run stopped", WatchdogCycles);
    $display("Some tests failed");
    $finish;
  end

  initial
  begin
    arstN = 1'b0;
    run   = 1'b0;
    resetIdle();
    moveAndStore();
    aluOps();
    condMove();
    loadStoreRoundTrip();
    runGating();
    $display("Summary: %0d tests, %0d failed, %0d check errors",
             testsRun, testsFailed, errorCount);
    if (testsFailed == 0)
      $display("All tests passed");
    else
      $display("Some tests failed");
    $finish;
  end

endmodule
